// File: hw/pcFile.sv
`timescale 1ns/10ps

module pcFile (
    input  logic                clk,
    input  logic                rst,
    input  trapPkg::PCFileWrite wr,
    input  trapPkg::FetchID_t   rdAddr,
    output trapPkg::PCFileEntry rdData
);
    import trapPkg::*;

    // One entry per in-flight fetch bundle
    PCFileEntry entries [PC_FILE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            entries[wr.fetchID] <= wr.entry;
        end
    end

    // Same-cycle read for the trap stage
    assign rdData = entries[rdAddr];

    // A write with an unknown index would corrupt an arbitrary bundle
    wrIdKnown: assert property (
        @(posedge clk) disable iff (rst)
        wr.valid |-> !$isunknown(wr.fetchID)
    );

endmodule

// File: hw/trapHandler.sv
`timescale 1ns/10ps

module trapHandler (
    input  logic                     clk,
    input  logic                     rst,
    input  trapPkg::Trap_UOp         trapInstr,
    output trapPkg::FetchID_t        pcReadAddr,
    input  trapPkg::PCFileEntry      pcReadData,
    input  trapPkg::TrapControlState trapControl,
    input  logic                     memBusy,
    output trapPkg::TrapInfoUpdate   trapInfo,
    output trapPkg::BranchProv       branch,
    output trapPkg::BPUpdate1        bpUpdate,
    output logic                     flushTLB,
    output logic                     fence,
    output logic                     clearICache,
    output logic                     fetchDisable,
    output logic [31:0]              dbgStallPC
);
    import trapPkg::*;

    logic [30:0] instrHw;
    logic [31:0] instrPC;
    logic [31:0] nextPC;
    logic [31:0] retPC;
    logic isSfence, isTrapIrq, isStoreFault, irqOnFlush;
    logic isFlush, isExc, isPred, isDbg;
    TrapCause_t excCause;
    TrapCause_t trapCause;
    logic trapDelegate;
    TrapInfoUpdate trapInfoC;
    BPUpdate1 bpUpdateC;
    logic fenceC, clearICacheC, flushTLBC, setMemWait, memWait;

    assign pcReadAddr = trapInstr.fetchID;

    // Offset points at the last halfword of the instruction
    assign instrHw = {pcReadData.pc[31:FETCH_OFF_W+1], trapInstr.fetchOffs}
        - 31'(!trapInstr.compressed);
    assign instrPC = {instrHw, 1'b0};
    assign nextPC = {instrHw + (trapInstr.compressed ? 31'd1 : 31'd2), 1'b0};
    assign retPC = {trapControl.retvec, 1'b0};

    assign isSfence = trapInstr.flags == FLAGS_TRAP && trapInstr.rd.vec == TRAP_V_SFENCE_VMA;
    assign isTrapIrq = trapInstr.flags == FLAGS_TRAP && trapInstr.rd.vec == TRAP_V_INTERRUPT;
    assign isStoreFault = trapInstr.flags inside {FLAGS_ST_MA, FLAGS_ST_AF, FLAGS_ST_PF};

    assign isFlush = trapInstr.valid && (isSfence
        || trapInstr.flags inside {FLAGS_FENCE, FLAGS_ORDERING, FLAGS_XRET});
    assign isExc = trapInstr.valid && !isFlush
        && trapInstr.flags inside {[FLAGS_ILLEGAL_INSTR:FLAGS_ST_PF]};
    assign isPred = trapInstr.valid
        && trapInstr.flags inside {FLAGS_PRED_TAKEN, FLAGS_PRED_NTAKEN};
    assign isDbg = trapInstr.valid && trapInstr.flags == FLAGS_NX;

    // Pending interrupts are taken at the next serializing point
    assign irqOnFlush = isFlush && trapControl.interruptPending
        && trapInstr.flags inside {FLAGS_ORDERING, FLAGS_XRET};

    always_comb begin
        case (trapInstr.flags)
            FLAGS_TRAP: excCause = TrapCause_t'(trapInstr.rd.idx[3:0]);
            FLAGS_LD_MA: excCause = CAUSE_LD_MA;
            FLAGS_LD_AF: excCause = CAUSE_LD_AF;
            FLAGS_LD_PF: excCause = CAUSE_LD_PF;
            FLAGS_ST_MA: excCause = CAUSE_ST_MA;
            FLAGS_ST_AF: excCause = CAUSE_ST_AF;
            FLAGS_ST_PF: excCause = CAUSE_ST_PF;
            default: excCause = CAUSE_ILLEGAL;
        endcase
        // ecall is encoded as M-mode, the real cause depends on priv
        if (excCause == CAUSE_ECALL_M) begin
            case (trapControl.priv)
                PRIV_SUPERVISOR: excCause = CAUSE_ECALL_S;
                PRIV_USER: excCause = CAUSE_ECALL_U;
                default: excCause = CAUSE_ECALL_M;
            endcase
        end
    end

    assign trapCause = isTrapIrq ? trapControl.interruptCause : excCause;
    assign trapDelegate = isTrapIrq ? trapControl.interruptDelegate
        : (trapControl.priv != PRIV_MACHINE) && trapControl.medeleg[excCause];

    always_comb begin
        branch = '0;
        trapInfoC = '0;
        bpUpdateC = '0;
        fenceC = 1'b0;
        clearICacheC = 1'b0;
        flushTLBC = 1'b0;
        setMemWait = 1'b0;

        if (isFlush || isExc) begin
            branch.taken = 1'b1;
            branch.flush = 1'b1;
            branch.sqN = trapInstr.sqN;
            branch.storeSqN = trapInstr.storeSqN - SqN_t'(isStoreFault);
            branch.loadSqN = trapInstr.loadSqN;
            branch.fetchID = trapInstr.fetchID;
        end

        if (isFlush) begin
            branch.dstPC = (trapInstr.flags == FLAGS_XRET) ? retPC : nextPC;
            case (trapInstr.flags)
                FLAGS_FENCE: begin
                    fenceC = 1'b1;
                    clearICacheC = 1'b1;
                    setMemWait = 1'b1;
                end
                FLAGS_ORDERING: setMemWait = 1'b1;
                FLAGS_TRAP: flushTLBC = 1'b1;
                default: ;
            endcase
            if (irqOnFlush) begin
                trapInfoC.valid = 1'b1;
                trapInfoC.trapPC = branch.dstPC;
                trapInfoC.cause = trapControl.interruptCause;
                trapInfoC.delegate = trapControl.interruptDelegate;
                trapInfoC.isInterrupt = 1'b1;
                branch.dstPC = {trapControl.interruptDelegate ? trapControl.stvec
                    : trapControl.mtvec, 2'b00};
            end
        end else if (isExc) begin
            trapInfoC.valid = 1'b1;
            trapInfoC.trapPC = instrPC;
            trapInfoC.cause = trapCause;
            trapInfoC.delegate = trapDelegate;
            trapInfoC.isInterrupt = isTrapIrq;
            branch.dstPC = {trapDelegate ? trapControl.stvec : trapControl.mtvec, 2'b00};
        end else if (isPred) begin
            bpUpdateC.valid = 1'b1;
            bpUpdateC.pc = pcReadData.pc;
            bpUpdateC.bpi = pcReadData.bpi;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trapInfo.valid <= 1'b0;
            bpUpdate.valid <= 1'b0;
            fence <= 1'b0;
            clearICache <= 1'b0;
            flushTLB <= 1'b0;
            dbgStallPC <= '0;
            memWait <= 1'b0;
        end else begin
            trapInfo <= trapInfoC;
            bpUpdate <= bpUpdateC;
            fence <= fenceC;
            clearICache <= clearICacheC;
            flushTLB <= flushTLBC;
            if (isDbg) begin
                dbgStallPC <= instrPC;
            end
            // Hold fetch until the memory side has drained
            if (setMemWait) begin
                memWait <= 1'b1;
            end else if (memWait && !memBusy) begin
                memWait <= 1'b0;
            end
        end
    end

    assign fetchDisable = memWait;

    flagsClassified: assert property (
        @(posedge clk) disable iff (rst)
        trapInstr.valid |-> (isFlush || isExc || isPred || isDbg)
    );

endmodule

// File: hw/trapPkg.sv
package trapPkg;

    localparam int FETCH_ID_W = 4;
    localparam int FETCH_OFF_W = 2;
    localparam int SQN_W = 6;
    localparam int PC_FILE_DEPTH = 1 << FETCH_ID_W;

    typedef logic [FETCH_ID_W-1:0] FetchID_t;
    typedef logic [FETCH_OFF_W-1:0] FetchOff_t;
    typedef logic [SQN_W-1:0] SqN_t;

    // Exceptions are the contiguous range ILLEGAL_INSTR .. ST_PF
    typedef enum logic [3:0] {
        FLAGS_NONE,
        FLAGS_NX,
        FLAGS_FENCE,
        FLAGS_ORDERING,
        FLAGS_XRET,
        FLAGS_ILLEGAL_INSTR,
        FLAGS_TRAP,
        FLAGS_LD_MA,
        FLAGS_LD_AF,
        FLAGS_LD_PF,
        FLAGS_ST_MA,
        FLAGS_ST_AF,
        FLAGS_ST_PF,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN
    } UopFlags_t;

    // Trap codes carried in rd for FLAGS_TRAP
    typedef enum logic [4:0] {
        TRAP_V_INSTR_MA = 5'd0,
        TRAP_V_INSTR_AF = 5'd1,
        TRAP_V_ILLEGAL = 5'd2,
        TRAP_V_BREAKPOINT = 5'd3,
        TRAP_V_LD_MA = 5'd4,
        TRAP_V_LD_AF = 5'd5,
        TRAP_V_ST_MA = 5'd6,
        TRAP_V_ST_AF = 5'd7,
        TRAP_V_ECALL_U = 5'd8,
        TRAP_V_ECALL_S = 5'd9,
        TRAP_V_ECALL_M = 5'd11,
        TRAP_V_INSTR_PF = 5'd12,
        TRAP_V_LD_PF = 5'd13,
        TRAP_V_ST_PF = 5'd15,
        TRAP_V_SFENCE_VMA = 5'd16,
        TRAP_V_INTERRUPT = 5'd17
    } TrapVec_t;

    typedef enum logic [3:0] {
        CAUSE_ILLEGAL = 4'd2,
        CAUSE_LD_MA = 4'd4,
        CAUSE_LD_AF = 4'd5,
        CAUSE_ST_MA = 4'd6,
        CAUSE_ST_AF = 4'd7,
        CAUSE_ECALL_U = 4'd8,
        CAUSE_ECALL_S = 4'd9,
        CAUSE_ECALL_M = 4'd11,
        CAUSE_LD_PF = 4'd13,
        CAUSE_ST_PF = 4'd15
    } TrapCause_t;

    typedef enum logic [1:0] {
        PRIV_USER = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE = 2'd3
    } Priv_t;

    // Destination register index, or trap code on FLAGS_TRAP
    typedef union packed {
        logic [4:0] idx;
        TrapVec_t vec;
    } RdField_u;

    typedef struct packed {
        logic valid;
        UopFlags_t flags;
        RdField_u rd;
        FetchID_t fetchID;
        FetchOff_t fetchOffs;
        logic compressed;
        SqN_t sqN;
        SqN_t storeSqN;
        SqN_t loadSqN;
    } Trap_UOp;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0] bpi;
    } PCFileEntry;

    typedef struct packed {
        logic valid;
        FetchID_t fetchID;
        PCFileEntry entry;
    } PCFileWrite;

    typedef struct packed {
        Priv_t priv;
        logic [29:0] mtvec;
        logic [29:0] stvec;
        logic [30:0] retvec;
        logic [15:0] medeleg;
        logic [15:0] mideleg;
        logic interruptPending;
        TrapCause_t interruptCause;
        logic interruptDelegate;
    } TrapControlState;

    typedef struct packed {
        logic valid;
        Priv_t priv;
        logic [29:0] mtvec;
        logic [29:0] stvec;
        logic [15:0] medeleg;
        logic [15:0] mideleg;
    } TrapConfig;

    typedef struct packed {
        logic valid;
        logic [31:0] trapPC;
        TrapCause_t cause;
        logic delegate;
        logic isInterrupt;
    } TrapInfoUpdate;

    typedef struct packed {
        logic taken;
        logic [31:0] dstPC;
        SqN_t sqN;
        SqN_t storeSqN;
        SqN_t loadSqN;
        FetchID_t fetchID;
        logic flush;
    } BranchProv;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [1:0] bpi;
    } BPUpdate1;

endpackage

// File: hw/trapState.sv
`timescale 1ns/10ps

module trapState (
    input  logic                     clk,
    input  logic                     rst,
    input  trapPkg::TrapConfig       cfg,
    input  logic                     irqReq,
    input  trapPkg::TrapCause_t      irqCause,
    input  trapPkg::TrapInfoUpdate   trapInfo,
    output trapPkg::TrapControlState ctrl
);
    import trapPkg::*;

    Priv_t priv;
    logic [29:0] mtvec;
    logic [29:0] stvec;
    logic [30:0] retvec;
    logic [15:0] medeleg;
    logic [15:0] mideleg;
    logic irqPending;
    TrapCause_t irqCauseQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_MACHINE;
            mtvec <= '0;
            stvec <= '0;
            retvec <= '0;
            medeleg <= '0;
            mideleg <= '0;
            irqPending <= 1'b0;
            irqCauseQ <= CAUSE_ILLEGAL;
        end else begin
            if (cfg.valid) begin
                priv <= cfg.priv;
                mtvec <= cfg.mtvec;
                stvec <= cfg.stvec;
                medeleg <= cfg.medeleg;
                mideleg <= cfg.mideleg;
            end
            // Trap entry overrides a concurrent privilege write
            if (trapInfo.valid) begin
                retvec <= trapInfo.trapPC[31:1];
                priv <= trapInfo.delegate ? PRIV_SUPERVISOR : PRIV_MACHINE;
            end
            irqPending <= irqReq;
            irqCauseQ <= irqCause;
        end
    end

    always_comb begin
        ctrl.priv = priv;
        ctrl.mtvec = mtvec;
        ctrl.stvec = stvec;
        ctrl.retvec = retvec;
        ctrl.medeleg = medeleg;
        ctrl.mideleg = mideleg;
        ctrl.interruptPending = irqPending;
        ctrl.interruptCause = irqCauseQ;
        // Interrupts can only go to S-mode from below M-mode
        ctrl.interruptDelegate = (priv != PRIV_MACHINE) && mideleg[irqCauseQ];
    end

    privLegal: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.priv != Priv_t'(2'b10)
    );

endmodule

// File: hw/trapUnit.sv
`timescale 1ns/10ps

module trapUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  trapPkg::PCFileWrite    pcWrite,
    input  trapPkg::Trap_UOp       trapInstr,
    input  trapPkg::TrapConfig     cfg,
    input  logic                   irqReq,
    input  trapPkg::TrapCause_t    irqCause,
    input  logic                   memBusy,
    output trapPkg::BranchProv     branch,
    output trapPkg::TrapInfoUpdate trapInfo,
    output trapPkg::BPUpdate1      bpUpdate,
    output logic                   flushTLB,
    output logic                   fence,
    output logic                   clearICache,
    output logic                   fetchDisable,
    output logic [31:0]            dbgStallPC
);
    import trapPkg::*;

    FetchID_t pcReadAddr;
    PCFileEntry pcReadData;
    TrapControlState trapControl;

    pcFile i_pcFile (
        .clk(clk),
        .rst(rst),
        .wr(pcWrite),
        .rdAddr(pcReadAddr),
        .rdData(pcReadData)
    );

    trapState i_trapState (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .irqReq(irqReq),
        .irqCause(irqCause),
        .trapInfo(trapInfo),
        .ctrl(trapControl)
    );

    trapHandler i_trapHandler (
        .clk(clk),
        .rst(rst),
        .trapInstr(trapInstr),
        .pcReadAddr(pcReadAddr),
        .pcReadData(pcReadData),
        .trapControl(trapControl),
        .memBusy(memBusy),
        .trapInfo(trapInfo),
        .branch(branch),
        .bpUpdate(bpUpdate),
        .flushTLB(flushTLB),
        .fence(fence),
        .clearICache(clearICache),
        .fetchDisable(fetchDisable),
        .dbgStallPC(dbgStallPC)
    );

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the trap unit testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f trapUnit.f --top-module trapUnitTb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/VtrapUnitTb > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

// File: trapUnit.f
hw/trapPkg.sv
hw/pcFile.sv
hw/trapState.sv
hw/trapHandler.sv
hw/trapUnit.sv
verif/tbClock.sv
verif/trapUnitTb.sv

// File: verif/tbClock.sv
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// File: verif/trapUnitTb.sv
`timescale 1ns/10ps

module trapUnitTb;
    import trapPkg::*;

    // The tests take under 200 cycles
    localparam int TIMEOUT_CYCLES = 400;

    typedef struct packed {
        logic fence;
        logic clearICache;
        logic flushTLB;
        logic fetchDisable;
        logic [31:0] dbgStallPC;
    } Pulses_t;

    typedef struct packed {
        BranchProv br;
        TrapInfoUpdate info;
        BPUpdate1 bp;
        logic fence;
        logic clearICache;
        logic flushTLB;
        logic setWait;
        logic dbgValid;
        logic [31:0] dbgPC;
    } Expect_t;

    logic clk, rst;
    PCFileWrite pcWrite;
    Trap_UOp trapInstr;
    TrapConfig cfg;
    logic irqReq;
    TrapCause_t irqCause;
    logic memBusy;
    BranchProv branch;
    TrapInfoUpdate trapInfo;
    BPUpdate1 bpUpdate;
    logic flushTLB, fence, clearICache, fetchDisable;
    logic [31:0] dbgStallPC;

    logic [31:0] lcgState = 32'd19154;
    int cycles = 0;
    PCFileEntry pcMem [16];
    TrapControlState model;
    Expect_t cur, prev;
    logic expFd;
    logic [31:0] expDbg;

    tbClock i_clock (.clk(clk), .rst(rst));

    trapUnit i_dut (
        .clk(clk), .rst(rst), .pcWrite(pcWrite), .trapInstr(trapInstr), .cfg(cfg),
        .irqReq(irqReq), .irqCause(irqCause), .memBusy(memBusy), .branch(branch),
        .trapInfo(trapInfo), .bpUpdate(bpUpdate), .flushTLB(flushTLB), .fence(fence),
        .clearICache(clearICache), .fetchDisable(fetchDisable), .dbgStallPC(dbgStallPC)
    );

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] vecTarget(TrapControlState s, logic deleg);
        return {deleg ? s.stvec : s.mtvec, 2'b00};
    endfunction

    // Expected outputs derived from the trap rules
    function automatic Expect_t refModel(Trap_UOp u, PCFileEntry e, TrapControlState s);
        Expect_t x;
        logic [31:0] ipc, npc, redirect;
        logic [3:0] cause;
        logic deleg;
        x = '0;
        if (!u.valid) return x;
        ipc = {e.pc[31:3], 3'b000} + {29'd0, u.fetchOffs, 1'b0} - (u.compressed ? 32'd0 : 32'd2);
        npc = ipc + (u.compressed ? 32'd2 : 32'd4);
        if (u.flags inside {FLAGS_PRED_TAKEN, FLAGS_PRED_NTAKEN}) begin
            x.bp.valid = 1'b1;
            x.bp.pc = e.pc;
            x.bp.bpi = e.bpi;
            return x;
        end
        if (u.flags == FLAGS_NX) begin
            x.dbgValid = 1'b1;
            x.dbgPC = ipc;
            return x;
        end
        x.br.taken = 1'b1;
        x.br.flush = 1'b1;
        x.br.sqN = u.sqN;
        x.br.storeSqN = u.storeSqN;
        x.br.loadSqN = u.loadSqN;
        x.br.fetchID = u.fetchID;
        if (u.flags inside {FLAGS_FENCE, FLAGS_ORDERING, FLAGS_XRET}) begin
            redirect = (u.flags == FLAGS_XRET) ? {s.retvec, 1'b0} : npc;
            x.br.dstPC = redirect;
            x.fence = u.flags == FLAGS_FENCE;
            x.clearICache = u.flags == FLAGS_FENCE;
            x.setWait = u.flags != FLAGS_XRET;
            if (s.interruptPending && u.flags != FLAGS_FENCE) begin
                deleg = s.priv != PRIV_MACHINE && s.mideleg[s.interruptCause];
                x.info.valid = 1'b1;
                x.info.trapPC = redirect;
                x.info.cause = s.interruptCause;
                x.info.delegate = deleg;
                x.info.isInterrupt = 1'b1;
                x.br.dstPC = vecTarget(s, deleg);
            end
        end else if (u.flags == FLAGS_TRAP && u.rd.idx == 5'd16) begin
            x.br.dstPC = npc;
            x.flushTLB = 1'b1;
        end else begin
            case (u.flags)
                FLAGS_LD_MA: cause = 4'd4;
                FLAGS_LD_AF: cause = 4'd5;
                FLAGS_LD_PF: cause = 4'd13;
                FLAGS_ST_MA: cause = 4'd6;
                FLAGS_ST_AF: cause = 4'd7;
                FLAGS_ST_PF: cause = 4'd15;
                FLAGS_TRAP: cause = u.rd.idx[3:0];
                default: cause = 4'd2;
            endcase
            if (cause == 4'd11 && s.priv == PRIV_USER) cause = 4'd8;
            if (cause == 4'd11 && s.priv == PRIV_SUPERVISOR) cause = 4'd9;
            deleg = s.priv != PRIV_MACHINE && s.medeleg[cause];
            if (u.flags inside {FLAGS_ST_MA, FLAGS_ST_AF, FLAGS_ST_PF}) begin
                x.br.storeSqN = u.storeSqN - 6'd1;
            end
            x.info.valid = 1'b1;
            x.info.trapPC = ipc;
            x.info.cause = TrapCause_t'(cause);
            x.info.delegate = deleg;
            x.br.dstPC = vecTarget(s, deleg);
        end
        return x;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkBranch(BranchProv act, BranchProv exp);
        if (act !== exp) failRun($sformatf("Mismatch at %0t: branch %h, expected %h",
            $time, act, exp));
    endtask

    task automatic checkTrapInfo(TrapInfoUpdate act, TrapInfoUpdate exp);
        if (act.valid !== exp.valid || (exp.valid && act !== exp))
            failRun($sformatf("Mismatch at %0t: trapInfo %h, expected %h", $time, act, exp));
    endtask

    task automatic checkBpUpdate(BPUpdate1 act, BPUpdate1 exp);
        if (act.valid !== exp.valid || (exp.valid && act !== exp))
            failRun($sformatf("Mismatch at %0t: bpUpdate %h, expected %h", $time, act, exp));
    endtask

    task automatic checkPulses(Pulses_t act, Pulses_t exp);
        if (act !== exp) failRun($sformatf("Mismatch at %0t: pulses %h, expected %h",
            $time, act, exp));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) failRun("Timeout: the test did not finish in time");
    end

    // Branch is checked in the uop's cycle and the registered outputs one cycle later
    initial begin
        Pulses_t actP, expP;
        prev = '0;
        expFd = 1'b0;
        expDbg = '0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            checkBranch(branch, cur.br);
            checkTrapInfo(trapInfo, prev.info);
            checkBpUpdate(bpUpdate, prev.bp);
            actP = {fence, clearICache, flushTLB, fetchDisable, dbgStallPC};
            expP = {prev.fence, prev.clearICache, prev.flushTLB, expFd, expDbg};
            checkPulses(actP, expP);
            if (cur.setWait) expFd = 1'b1;
            else if (expFd && !memBusy) expFd = 1'b0;
            if (cur.dbgValid) expDbg = cur.dbgPC;
            prev = cur;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic Trap_UOp makeUop(UopFlags_t f, logic [4:0] rd);
        Trap_UOp u;
        logic [31:0] r;
        r = lcgNext();
        u.valid = 1'b1;
        u.flags = f;
        u.rd.idx = rd;
        u.fetchID = r[19:16];
        u.fetchOffs = r[21:20];
        u.compressed = r[22];
        u.sqN = r[28:23];
        u.storeSqN = r[13:8];
        u.loadSqN = r[7:2];
        return u;
    endfunction

    // Uop for one cycle and then an idle cycle so the trap state settles
    task automatic sendUop(Trap_UOp u);
        tick();
        trapInstr = u;
        cur = refModel(u, pcMem[u.fetchID], model);
        if (cur.info.valid) begin
            model.retvec = cur.info.trapPC[31:1];
            model.priv = cur.info.delegate ? PRIV_SUPERVISOR : PRIV_MACHINE;
        end
        tick();
        trapInstr = '0;
        cur = '0;
    endtask

    task automatic writeCfg(Priv_t p, logic [15:0] med, logic [15:0] mid);
        logic [31:0] r1, r2;
        r1 = lcgNext();
        r2 = lcgNext();
        tick();
        cfg = {1'b1, p, r1[31:2], r2[31:2], med, mid};
        model.priv = p;
        model.mtvec = r1[31:2];
        model.stvec = r2[31:2];
        model.medeleg = med;
        model.mideleg = mid;
        tick();
        cfg = '0;
    endtask

    task automatic flushWithBusy(UopFlags_t f);
        logic [31:0] r;
        r = lcgNext();
        tick();
        memBusy = 1'b1;
        trapInstr = makeUop(f, 5'd0);
        cur = refModel(trapInstr, pcMem[trapInstr.fetchID], model);
        tick();
        trapInstr = '0;
        cur = '0;
        repeat (1 + r[18:16] % 6) tick();
        memBusy = 1'b0;
        while (fetchDisable === 1'b1) tick();
    endtask

    initial begin
        logic [31:0] r;
        UopFlags_t f;
        Priv_t privs [3];
        pcWrite = '0;
        trapInstr = '0;
        cfg = '0;
        irqReq = 1'b0;
        irqCause = CAUSE_ILLEGAL;
        memBusy = 1'b0;
        cur = '0;
        model = '0;
        model.priv = PRIV_MACHINE;
        model.interruptCause = CAUSE_ILLEGAL;
        privs = '{PRIV_USER, PRIV_SUPERVISOR, PRIV_MACHINE};
        wait (rst === 1'b0);
        for (int i = 0; i < 16; i++) begin
            r = lcgNext();
            tick();
            pcMem[i] = {r[31:2], 2'b00, 2'(lcgNext() >> 30)};
            pcWrite = {1'b1, 4'(i), pcMem[i]};
        end
        tick();
        pcWrite = '0;

        // Random exceptions under changing privilege and delegation
        for (int i = 0; i < 24; i++) begin
            if (i % 4 == 0) begin
                r = lcgNext();
                writeCfg(r[20] ? PRIV_SUPERVISOR : PRIV_MACHINE, r[15:0], r[31:16]);
            end
            r = lcgNext();
            f = UopFlags_t'(4'd5 + {1'b0, r[18:16]});
            sendUop(makeUop(f, (f == FLAGS_TRAP) ? (r[24] ? 5'd11 : 5'd3) : r[29:25]));
        end

        // Each ecall is sent twice so the second sees the privilege left by the first
        foreach (privs[i]) begin
            writeCfg(privs[i], 16'h0B00, 16'h0000);
            sendUop(makeUop(FLAGS_TRAP, 5'd11));
            sendUop(makeUop(FLAGS_TRAP, 5'd11));
        end

        flushWithBusy(FLAGS_FENCE);
        flushWithBusy(FLAGS_ORDERING);
        flushWithBusy(FLAGS_FENCE);
        flushWithBusy(FLAGS_ORDERING);

        sendUop(makeUop(FLAGS_TRAP, 5'd16));
        sendUop(makeUop(FLAGS_LD_AF, 5'd0));
        sendUop(makeUop(FLAGS_XRET, 5'd0));

        // External interrupt taken at ordering and xRET
        writeCfg(PRIV_SUPERVISOR, 16'h0000, 16'h0020);
        tick();
        irqReq = 1'b1;
        irqCause = CAUSE_LD_AF;
        model.interruptPending = 1'b1;
        model.interruptCause = CAUSE_LD_AF;
        sendUop(makeUop(FLAGS_ORDERING, 5'd0));
        while (fetchDisable === 1'b1) tick();
        sendUop(makeUop(FLAGS_XRET, 5'd0));
        writeCfg(PRIV_MACHINE, 16'h0000, 16'h0020);
        sendUop(makeUop(FLAGS_XRET, 5'd0));
        tick();
        irqReq = 1'b0;
        model.interruptPending = 1'b0;

        sendUop(makeUop(FLAGS_PRED_TAKEN, 5'd0));
        sendUop(makeUop(FLAGS_PRED_NTAKEN, 5'd0));
        sendUop(makeUop(FLAGS_NX, 5'd0));
        sendUop(makeUop(FLAGS_NX, 5'd0));
        tick();
        tick();
        $display("Test OK");
        $finish;
    end

endmodule
